//--- source/rename_core_params.svh
`ifndef RENAME_CORE_PARAMS_SVH
`define RENAME_CORE_PARAMS_SVH

// Physical register file with register 0 hardwired to zero
`define PHYS_REGS 48
`define PHYS_ADDR_W 6

// Reorder buffer
`define ROB_DEPTH 8
`define ROB_ADDR_W 3

// Byte address of the first fetch
`define RESET_PC 32'h0000_0000

`endif

//--- source/rename_core_pkg.sv
package rename_core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS
  } alu_cmd_t;

  // Second ALU operand
  typedef enum logic {
    SRC_REG,
    SRC_IMM
  } op_type_t;

  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_BUS,
    FETCH_HOLD,
    FETCH_HALT
  } fetch_state_t;

endpackage

//--- source/fetch_ctrl.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module fetch_ctrl (
  input  logic        clk,
  input  logic        rst,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic [29:0] wb_adr,
  input  logic [31:0] wb_rdata,
  input  logic        wb_ack,
  input  logic        rename_stall,
  input  logic        is_halt,
  output logic [31:0] instr,
  output logic        instr_valid
);

  rename_core_pkg::fetch_state_t state;
  logic [31:0] pc;

  // Bus cycle lasts exactly as long as the BUS state
  assign wb_cyc = (state == rename_core_pkg::FETCH_BUS);
  assign wb_stb = wb_cyc;
  assign wb_adr = pc[31:2];
  assign instr_valid = (state == rename_core_pkg::FETCH_HOLD);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rename_core_pkg::FETCH_IDLE;
      pc <= `RESET_PC;
    end else begin
      case (state)
        rename_core_pkg::FETCH_IDLE: state <= rename_core_pkg::FETCH_BUS;
        rename_core_pkg::FETCH_BUS: begin
          if (wb_ack) begin
            state <= rename_core_pkg::FETCH_HOLD;
          end
        end
        rename_core_pkg::FETCH_HOLD: begin
          // Word leaves the instruction register
          if (!rename_stall) begin
            pc <= pc + 32'd4;
            state <= is_halt ? rename_core_pkg::FETCH_HALT : rename_core_pkg::FETCH_BUS;
          end
        end
        default: state <= rename_core_pkg::FETCH_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wb_cyc && wb_ack) begin
      instr <= wb_rdata;
    end
  end

endmodule

//--- source/decoder.sv
`timescale 1ns/1ns

module decoder (
  input  logic [31:0]               instr,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  output logic [4:0]                rd,
  output rename_core_pkg::alu_cmd_t alu_cmd,
  output rename_core_pkg::op_type_t op_type,
  output logic [31:0]               imm,
  output logic                      writes_rd,
  output logic                      is_halt,
  output logic                      illegal
);

  rename_core_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = rename_core_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  function automatic rename_core_pkg::alu_cmd_t alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: alu_of = alt ? rename_core_pkg::ALU_SUB : rename_core_pkg::ALU_ADD;
      3'b001: alu_of = rename_core_pkg::ALU_SLL;
      3'b010: alu_of = rename_core_pkg::ALU_SLT;
      3'b011: alu_of = rename_core_pkg::ALU_SLTU;
      3'b100: alu_of = rename_core_pkg::ALU_XOR;
      3'b101: alu_of = alt ? rename_core_pkg::ALU_SRA : rename_core_pkg::ALU_SRL;
      3'b110: alu_of = rename_core_pkg::ALU_OR;
      default: alu_of = rename_core_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    rs1 = 5'd0;
    rs2 = 5'd0;
    rd = instr[11:7];
    alu_cmd = rename_core_pkg::ALU_ADD;
    op_type = rename_core_pkg::SRC_IMM;
    imm = {{20{instr[31]}}, instr[31:20]};
    illegal = 1'b0;
    is_halt = 1'b0;
    case (opcode)
      rename_core_pkg::OPC_OP: begin
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        op_type = rename_core_pkg::SRC_REG;
        alu_cmd = alu_of(funct3, instr[30]);
        // Only SUB and SRA use the alternate funct7
        illegal = (funct7 != 7'h00) &&
                  !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rename_core_pkg::OPC_OP_IMM: begin
        rs1 = instr[19:15];
        alu_cmd = alu_of(funct3, instr[30] && funct3 == 3'b101);
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      rename_core_pkg::OPC_LUI: begin
        alu_cmd = rename_core_pkg::ALU_PASS;
        imm = {instr[31:12], 12'h000};
      end
      rename_core_pkg::OPC_SYSTEM: begin
        is_halt = 1'b1;
        illegal = (instr != 32'h0010_0073);
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      is_halt = 1'b1;
    end
    writes_rd = !is_halt && (rd != 5'd0);
  end

endmodule

//--- source/rename_stage.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module rename_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,
  input  logic [4:0]                rs1,
  input  logic [4:0]                rs2,
  input  logic [4:0]                rd,
  input  rename_core_pkg::alu_cmd_t alu_cmd,
  input  rename_core_pkg::op_type_t op_type,
  input  logic [31:0]               imm,
  input  logic                      writes_rd,
  output logic                      rename_stall,
  output logic                      pop_en,
  input  logic [`PHYS_ADDR_W-1:0]   pop_reg,
  input  logic                      free_empty,
  input  logic                      rob_full,
  output logic                      rob_alloc,
  input  logic [`ROB_ADDR_W-1:0]    rob_idx,
  input  logic                      exec_stall,
  output logic                      busy_set,
  output logic                      iss_valid,
  output rename_core_pkg::alu_cmd_t iss_alu_cmd,
  output rename_core_pkg::op_type_t iss_op_type,
  output logic [31:0]               iss_imm,
  output logic [`PHYS_ADDR_W-1:0]   iss_phys_rs1,
  output logic [`PHYS_ADDR_W-1:0]   iss_phys_rs2,
  output logic [`PHYS_ADDR_W-1:0]   iss_phys_rd,
  output logic                      iss_writes_rd,
  output logic [`ROB_ADDR_W-1:0]    iss_rob_idx,
  output logic [`PHYS_ADDR_W-1:0]   old_rd,
  output logic [4:0]                arch_rd
);

  localparam int PA = `PHYS_ADDR_W;

  // Speculative architectural to physical map
  logic [PA-1:0] map_table [32];
  logic accept;

  assign rename_stall = instr_valid &&
                        ((writes_rd && free_empty) || rob_full || (iss_valid && exec_stall));
  assign accept = instr_valid && !rename_stall;
  assign pop_en = accept && writes_rd;
  assign busy_set = pop_en;
  assign rob_alloc = accept;
  assign old_rd = map_table[rd];
  assign arch_rd = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        map_table[i] <= PA'(i);
      end
    end else if (pop_en) begin
      map_table[rd] <= pop_reg;
    end
  end

  // Held while the ALU waits on a busy source
  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else if (accept) begin
      iss_valid <= 1'b1;
    end else if (!exec_stall) begin
      iss_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss_alu_cmd <= alu_cmd;
      iss_op_type <= op_type;
      iss_imm <= imm;
      iss_phys_rs1 <= map_table[rs1];
      iss_phys_rs2 <= map_table[rs2];
      iss_phys_rd <= writes_rd ? pop_reg : '0;
      iss_writes_rd <= writes_rd;
      iss_rob_idx <= rob_idx;
    end
  end

endmodule

//--- source/free_list.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module free_list (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pop_en,
  output logic [`PHYS_ADDR_W-1:0] pop_reg,
  input  logic                    push_en,
  input  logic [`PHYS_ADDR_W-1:0] push_reg,
  output logic                    empty
);

  // At most PHYS_REGS - 32 registers are ever free
  localparam int DEPTH = `PHYS_REGS - 32;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int PA = `PHYS_ADDR_W;

  logic [PA-1:0]    slots [DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  assign pop_reg = slots[head];
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= CNT_W'(DEPTH);
      for (int i = 0; i < DEPTH; i++) begin
        slots[i] <= PA'(32 + i);
      end
    end else begin
      if (pop_en) begin
        head <= head + 1'b1;
      end
      if (push_en) begin
        slots[tail] <= push_reg;
        tail <= tail + 1'b1;
      end
      count <= count + CNT_W'(push_en) - CNT_W'(pop_en);
    end
  end

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module reorder_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    alloc,
  input  logic [4:0]              arch_rd,
  input  logic [`PHYS_ADDR_W-1:0] phys_rd,
  input  logic [`PHYS_ADDR_W-1:0] old_rd,
  input  logic                    writes_rd,
  input  logic                    is_halt,
  input  logic                    illegal,
  output logic [`ROB_ADDR_W-1:0]  alloc_idx,
  output logic                    full,
  input  logic                    done_en,
  input  logic [`ROB_ADDR_W-1:0]  done_idx,
  output logic [`PHYS_ADDR_W-1:0] commit_phys,
  input  logic [31:0]             commit_rdata,
  output logic                    commit_valid,
  output logic [4:0]              commit_rd,
  output logic [31:0]             commit_data,
  output logic                    free_en,
  output logic [`PHYS_ADDR_W-1:0] free_reg,
  output logic                    halted,
  output logic                    illegal_instr
);

  localparam int RA = `ROB_ADDR_W;
  localparam int PA = `PHYS_ADDR_W;

  logic [4:0]    e_arch [`ROB_DEPTH];
  logic [PA-1:0] e_phys [`ROB_DEPTH];
  logic [PA-1:0] e_old [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] e_writes;
  logic [`ROB_DEPTH-1:0] e_halt;
  logic [`ROB_DEPTH-1:0] e_illegal;
  logic [`ROB_DEPTH-1:0] e_done;
  logic [RA-1:0] head;
  logic [RA-1:0] tail;
  logic [RA:0]   count;
  logic          retire;

  assign alloc_idx = tail;
  assign full = (count == (RA + 1)'(`ROB_DEPTH));
  assign retire = (count != '0) && e_done[head];
  assign commit_phys = e_phys[head];
  // Previous mapping of rd becomes free once the new one is architectural
  assign free_en = retire && e_writes[head] && (e_old[head] != '0);
  assign free_reg = e_old[head];

  always_ff @(posedge clk) begin
    if (alloc) begin
      e_arch[tail] <= arch_rd;
      e_phys[tail] <= phys_rd;
      e_old[tail] <= old_rd;
      e_writes[tail] <= writes_rd;
      e_halt[tail] <= is_halt;
      e_illegal[tail] <= illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      e_done <= '0;
      commit_valid <= 1'b0;
      halted <= 1'b0;
      illegal_instr <= 1'b0;
    end else begin
      if (alloc) begin
        e_done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (done_en) begin
        e_done[done_idx] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + (RA + 1)'(alloc) - (RA + 1)'(retire);
      commit_valid <= retire && e_writes[head];
      if (retire && e_halt[head] && !e_illegal[head]) begin
        halted <= 1'b1;
      end
      if (retire && e_illegal[head]) begin
        illegal_instr <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    commit_rd <= e_arch[head];
    commit_data <= commit_rdata;
  end

endmodule

//--- source/phys_regfile.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module phys_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`PHYS_ADDR_W-1:0] raddr1,
  input  logic [`PHYS_ADDR_W-1:0] raddr2,
  input  logic [`PHYS_ADDR_W-1:0] raddr3,
  output logic [31:0]             rdata1,
  output logic [31:0]             rdata2,
  output logic [31:0]             rdata3,
  output logic                    busy1,
  output logic                    busy2,
  input  logic                    wen,
  input  logic [`PHYS_ADDR_W-1:0] waddr,
  input  logic [31:0]             wdata,
  input  logic                    busy_set_en,
  input  logic [`PHYS_ADDR_W-1:0] busy_set_reg
);

  logic [31:0]            regs [`PHYS_REGS];
  logic [`PHYS_REGS-1:0]  busy;

  assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? 32'd0 : regs[raddr2];
  assign rdata3 = (raddr3 == '0) ? 32'd0 : regs[raddr3];
  assign busy1 = (raddr1 != '0) && busy[raddr1];
  assign busy2 = (raddr2 != '0) && busy[raddr2];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // Set at rename, cleared by the result write
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (busy_set_en) begin
        busy[busy_set_reg] <= 1'b1;
      end
      if (wen) begin
        busy[waddr] <= 1'b0;
      end
    end
  end

endmodule

//--- source/exec_unit.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module exec_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      iss_valid,
  input  rename_core_pkg::alu_cmd_t iss_alu_cmd,
  input  rename_core_pkg::op_type_t iss_op_type,
  input  logic [31:0]               iss_imm,
  input  logic [`PHYS_ADDR_W-1:0]   iss_phys_rs1,
  input  logic [`PHYS_ADDR_W-1:0]   iss_phys_rs2,
  input  logic [`PHYS_ADDR_W-1:0]   iss_phys_rd,
  input  logic                      iss_writes_rd,
  input  logic [`ROB_ADDR_W-1:0]    iss_rob_idx,
  output logic [`PHYS_ADDR_W-1:0]   raddr1,
  output logic [`PHYS_ADDR_W-1:0]   raddr2,
  input  logic [31:0]               rdata1,
  input  logic [31:0]               rdata2,
  input  logic                      busy1,
  input  logic                      busy2,
  output logic                      exec_stall,
  output logic                      wb_en,
  output logic [`PHYS_ADDR_W-1:0]   wb_reg,
  output logic [31:0]               wb_data,
  output logic                      done_en,
  output logic [`ROB_ADDR_W-1:0]    done_idx
);

  logic [31:0] op_b;
  logic [31:0] result;
  logic        wb_valid;
  logic        wb_writes;
  logic        fire;

  assign raddr1 = iss_phys_rs1;
  assign raddr2 = iss_phys_rs2;
  // Unused rs2 maps to register 0, which is never busy
  assign exec_stall = iss_valid && (busy1 || busy2);
  assign fire = iss_valid && !exec_stall;
  assign op_b = (iss_op_type == rename_core_pkg::SRC_IMM) ? iss_imm : rdata2;

  always_comb begin
    case (iss_alu_cmd)
      rename_core_pkg::ALU_ADD:  result = rdata1 + op_b;
      rename_core_pkg::ALU_SUB:  result = rdata1 - op_b;
      rename_core_pkg::ALU_AND:  result = rdata1 & op_b;
      rename_core_pkg::ALU_OR:   result = rdata1 | op_b;
      rename_core_pkg::ALU_XOR:  result = rdata1 ^ op_b;
      rename_core_pkg::ALU_SLT:  result = {31'd0, $signed(rdata1) < $signed(op_b)};
      rename_core_pkg::ALU_SLTU: result = {31'd0, rdata1 < op_b};
      rename_core_pkg::ALU_SLL:  result = rdata1 << op_b[4:0];
      rename_core_pkg::ALU_SRL:  result = rdata1 >> op_b[4:0];
      rename_core_pkg::ALU_SRA:  result = $unsigned($signed(rdata1) >>> op_b[4:0]);
      default:                   result = op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      wb_writes <= iss_writes_rd;
      wb_reg <= iss_phys_rd;
      wb_data <= result;
      done_idx <= iss_rob_idx;
    end
  end

  assign wb_en = wb_valid && wb_writes;
  assign done_en = wb_valid;

endmodule

//--- source/rename_core.sv
`timescale 1ns/1ns
`include "rename_core_params.svh"

module rename_core (
  input  logic        clk,
  input  logic        rst,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic [29:0] wb_adr,
  input  logic [31:0] wb_rdata,
  input  logic        wb_ack,
  output logic        commit_valid,
  output logic [4:0]  commit_rd,
  output logic [31:0] commit_data,
  output logic        halted,
  output logic        illegal_instr
);

  localparam int PA = `PHYS_ADDR_W;
  localparam int RA = `ROB_ADDR_W;

  // Fetch and decode
  logic [31:0] instr;
  logic        instr_valid;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [4:0]  dec_rd;
  rename_core_pkg::alu_cmd_t dec_alu_cmd;
  rename_core_pkg::op_type_t dec_op_type;
  logic [31:0] dec_imm;
  logic        dec_writes_rd;
  logic        dec_is_halt;
  logic        dec_illegal;

  // Rename
  logic          rename_stall;
  logic          pop_en;
  logic [PA-1:0] pop_reg;
  logic          free_empty;
  logic          rob_full;
  logic          rob_alloc;
  logic [RA-1:0] rob_idx;
  logic          busy_set;
  logic [PA-1:0] old_rd;
  logic [4:0]    arch_rd;

  // Issue
  logic                      iss_valid;
  rename_core_pkg::alu_cmd_t iss_alu_cmd;
  rename_core_pkg::op_type_t iss_op_type;
  logic [31:0]               iss_imm;
  logic [PA-1:0]             iss_phys_rs1;
  logic [PA-1:0]             iss_phys_rs2;
  logic [PA-1:0]             iss_phys_rd;
  logic                      iss_writes_rd;
  logic [RA-1:0]             iss_rob_idx;

  // Execute, writeback and commit
  logic [PA-1:0] raddr1;
  logic [PA-1:0] raddr2;
  logic [31:0]   rdata1;
  logic [31:0]   rdata2;
  logic          busy1;
  logic          busy2;
  logic          exec_stall;
  logic          wb_en;
  logic [PA-1:0] wb_reg;
  logic [31:0]   wb_data;
  logic          done_en;
  logic [RA-1:0] done_idx;
  logic [PA-1:0] commit_phys;
  logic [31:0]   commit_rdata;
  logic          free_en;
  logic [PA-1:0] free_reg;

  fetch_ctrl i_fetch_ctrl (
    .clk,
    .rst,
    .wb_cyc,
    .wb_stb,
    .wb_adr,
    .wb_rdata,
    .wb_ack,
    .rename_stall,
    .is_halt     (dec_is_halt),
    .instr,
    .instr_valid
  );

  decoder i_decoder (
    .instr,
    .rs1       (dec_rs1),
    .rs2       (dec_rs2),
    .rd        (dec_rd),
    .alu_cmd   (dec_alu_cmd),
    .op_type   (dec_op_type),
    .imm       (dec_imm),
    .writes_rd (dec_writes_rd),
    .is_halt   (dec_is_halt),
    .illegal   (dec_illegal)
  );

  rename_stage i_rename_stage (
    .clk,
    .rst,
    .instr_valid,
    .rs1          (dec_rs1),
    .rs2          (dec_rs2),
    .rd           (dec_rd),
    .alu_cmd      (dec_alu_cmd),
    .op_type      (dec_op_type),
    .imm          (dec_imm),
    .writes_rd    (dec_writes_rd),
    .rename_stall,
    .pop_en,
    .pop_reg,
    .free_empty,
    .rob_full,
    .rob_alloc,
    .rob_idx,
    .exec_stall,
    .busy_set,
    .iss_valid,
    .iss_alu_cmd,
    .iss_op_type,
    .iss_imm,
    .iss_phys_rs1,
    .iss_phys_rs2,
    .iss_phys_rd,
    .iss_writes_rd,
    .iss_rob_idx,
    .old_rd,
    .arch_rd
  );

  free_list i_free_list (
    .clk,
    .rst,
    .pop_en,
    .pop_reg,
    .push_en  (free_en),
    .push_reg (free_reg),
    .empty    (free_empty)
  );

  reorder_buffer i_reorder_buffer (
    .clk,
    .rst,
    .alloc         (rob_alloc),
    .arch_rd,
    .phys_rd       (pop_reg),
    .old_rd,
    .writes_rd     (dec_writes_rd),
    .is_halt       (dec_is_halt),
    .illegal       (dec_illegal),
    .alloc_idx     (rob_idx),
    .full          (rob_full),
    .done_en,
    .done_idx,
    .commit_phys,
    .commit_rdata,
    .commit_valid,
    .commit_rd,
    .commit_data,
    .free_en,
    .free_reg,
    .halted,
    .illegal_instr
  );

  phys_regfile i_phys_regfile (
    .clk,
    .rst,
    .raddr1,
    .raddr2,
    .raddr3       (commit_phys),
    .rdata1,
    .rdata2,
    .rdata3       (commit_rdata),
    .busy1,
    .busy2,
    .wen          (wb_en),
    .waddr        (wb_reg),
    .wdata        (wb_data),
    .busy_set_en  (busy_set),
    .busy_set_reg (pop_reg)
  );

  exec_unit i_exec_unit (
    .clk,
    .rst,
    .iss_valid,
    .iss_alu_cmd,
    .iss_op_type,
    .iss_imm,
    .iss_phys_rs1,
    .iss_phys_rs2,
    .iss_phys_rd,
    .iss_writes_rd,
    .iss_rob_idx,
    .raddr1,
    .raddr2,
    .rdata1,
    .rdata2,
    .busy1,
    .busy2,
    .exec_stall,
    .wb_en,
    .wb_reg,
    .wb_data,
    .done_en,
    .done_idx
  );

endmodule

//--- testbench/rename_core_properties.sv
`timescale 1ns/1ns

module rename_core_properties (
  input logic        clk,
  input logic        rst,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic [29:0] wb_adr,
  input logic        wb_ack,
  input logic        commit_valid,
  input logic        halted,
  input logic        illegal_instr
);

  int failures = 0;

  stb_matches_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb == wb_cyc)
    else begin
      $error("wb_stb differs from wb_cyc");
      failures++;
    end

  // Classic cycle holds the address until the slave acknowledges
  adr_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
    else begin
      $error("wb_adr changed or wb_cyc dropped before wb_ack");
      failures++;
    end

  no_commit_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !commit_valid)
    else begin
      $error("commit_valid high during reset");
      failures++;
    end

  no_commit_after_halt: assert property (@(posedge clk) disable iff (rst)
    (halted || illegal_instr) |-> !commit_valid)
    else begin
      $error("commit_valid high after the core halted");
      failures++;
    end

endmodule

//--- testbench/rename_core_tb.sv
`timescale 1ns/1ns

module rename_core_tb;

  localparam int MEM_WORDS = 256;
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 20;
  localparam string STIM_FILE = "testbench/rename_core_stim.txt";

  logic        clk = 1'b0;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic [29:0] wb_adr;
  logic [31:0] wb_rdata;
  logic        wb_ack;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [31:0] commit_data;
  logic        halted;
  logic        illegal_instr;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng_state = 32'd8;
  int          wait_left = -1;

  // One record per I, C or H line of the stim file
  byte         rec_tag [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_b [$];
  int          n_words;

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          value_errors = 0;
  int          other_errors = 0;

  rename_core i_rename_core (
    .clk,
    .rst,
    .wb_cyc,
    .wb_stb,
    .wb_adr,
    .wb_rdata,
    .wb_ack,
    .commit_valid,
    .commit_rd,
    .commit_data,
    .halted,
    .illegal_instr
  );

  bind rename_core rename_core_properties i_properties (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_adr        (wb_adr),
    .wb_ack        (wb_ack),
    .commit_valid  (commit_valid),
    .halted        (halted),
    .illegal_instr (illegal_instr)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unknown opcode, so a stray fetch commits as illegal
  function automatic logic [31:0] fill_word(input logic [29:0] adr);
    return {adr[24:0] ^ {20'd0, adr[29:25]}, 7'h7f};
  endfunction

  // Wishbone slave with 0 to 3 wait states per cycle
  always @(posedge clk) begin
    if (rst || wb_ack || !wb_cyc) begin
      wb_ack <= 1'b0;
      wait_left = -1;
    end else if (wb_stb) begin
      if (wait_left < 0) begin
        rng_state = xorshift32(rng_state);
        wait_left = int'(rng_state[1:0]);
      end
      if (wait_left == 0) begin
        wb_ack <= 1'b1;
        wb_rdata <= (wb_adr < 30'(MEM_WORDS)) ? mem[wb_adr[7:0]] : fill_word(wb_adr);
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  task automatic check_rd(input string name, input logic [4:0] expected,
                          input logic [4:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  always @(posedge clk) begin : commit_monitor
    logic [4:0]  want_rd;
    logic [31:0] want_data;
    if (!rst && commit_valid) begin
      if (exp_rd.size() == 0) begin
        other_errors++;
        $display("Unexpected commit of x%0d at %0t after the expected trace", commit_rd, $time);
      end else begin
        want_rd = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        check_rd("commit_rd", want_rd, commit_rd);
        check_data("commit_data", want_data, commit_data);
      end
    end
  end

  task automatic read_stim(output bit ok);
    int          fd;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    ok = 1'b0;
    n_words = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      return;
    end
    while ($fgets(line, fd) > 0) begin
      tag = line.getc(0);
      a = '0;
      b = '0;
      if ((tag == "I" && $sscanf(line, "I %h %h", a, b) == 2) ||
          (tag == "C" && $sscanf(line, "C %d %h", a, b) == 2) ||
          (tag == "H" && $sscanf(line, "H %d", a) == 1)) begin
        rec_tag.push_back(tag);
        rec_a.push_back(a);
        rec_b.push_back(b);
        if (tag == "I") begin
          n_words++;
        end
      end
    end
    $fclose(fd);
    ok = (rec_tag.size() > 0) && (rec_tag[rec_tag.size() - 1] == "H");
  endtask

  // Consumes records up to and including the next H line
  task automatic load_program(inout int idx, output int kind);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(30'(i));
    end
    exp_rd.delete();
    exp_data.delete();
    kind = 0;
    while (idx < rec_tag.size() && kind == 0) begin
      case (rec_tag[idx])
        "I": begin
          if (rec_a[idx] >= 32'(4 * MEM_WORDS)) begin
            other_errors++;
            $display("Program word at %h lies outside the memory model", rec_a[idx]);
          end else begin
            mem[rec_a[idx][9:2]] = rec_b[idx];
          end
        end
        "C": begin
          exp_rd.push_back(rec_a[idx][4:0]);
          exp_data.push_back(rec_b[idx]);
        end
        default: kind = int'(rec_a[idx]);
      endcase
      idx++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_program(input int kind);
    apply_reset();
    while (!halted && !illegal_instr) begin
      @(posedge clk);
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (exp_rd.size() != 0) begin
      other_errors++;
      $display("Core halted with %0d expected commits still missing", exp_rd.size());
    end
    check_flag("halted", kind == 1, halted);
    check_flag("illegal_instr", kind == 2, illegal_instr);
  endtask

  initial begin
    bit ok;
    int idx;
    int kind;
    int run;
    int limit;
    rst = 1'b1;
    wb_ack = 1'b0;
    wb_rdata = '0;
    read_stim(ok);
    if (!ok) begin
      other_errors++;
      $display("Stimulus file holds no complete program");
    end else begin
      limit = 40 * n_words + 200;
      fork
        begin
          repeat (limit) @(posedge clk);
          $display("Watchdog expired after %0d cycles without the run finishing", limit);
          $display("sim failed");
          $finish;
        end
      join_none
      idx = 0;
      run = 0;
      while (idx < rec_tag.size()) begin
        load_program(idx, kind);
        run++;
        $display("Run %0d: expecting %0d commits, halt kind %0d", run, exp_rd.size(), kind);
        run_program(kind);
      end
    end
    $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             i_rename_core.i_properties.failures);
    if (value_errors + other_errors + i_rename_core.i_properties.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- rename_core.f
+incdir+source
source/rename_core_pkg.sv
source/fetch_ctrl.sv
source/decoder.sv
source/rename_stage.sv
source/free_list.sv
source/reorder_buffer.sv
source/phys_regfile.sv
source/exec_unit.sv
source/rename_core.sv
testbench/rename_core_properties.sv
testbench/rename_core_tb.sv

//--- testbench/rename_core_stim.txt
# I byte_address word mnemonic / C rd(decimal) value(hex) / H halt kind (1 ebreak, 2 illegal)
# Commits are expected in the listed order and every H line closes one program
I 00000000 00500093 addi x1, x0, 5
C 1 00000005
I 00000004 ffd00113 addi x2, x0, -3
C 2 fffffffd
I 00000008 002081b3 add x3, x1, x2
C 3 00000002
I 0000000c 40208233 sub x4, x1, x2
C 4 00000008
I 00000010 001122b3 slt x5, x2, x1
C 5 00000001
I 00000014 00113333 sltu x6, x2, x1
C 6 00000000
I 00000018 123453b7 lui x7, 0x12345
C 7 12345000
I 0000001c 6783e393 ori x7, x7, 0x678
C 7 12345678
I 00000020 fff3c413 xori x8, x7, -1
C 8 edcba987
I 00000024 40445493 srai x9, x8, 4
C 9 fedcba98
I 00000028 00845513 srli x10, x8, 8
C 10 00edcba9
I 0000002c 00309593 slli x11, x1, 3
C 11 00000028
I 00000030 0f03f613 andi x12, x7, 0xf0
C 12 00000070
I 00000034 00708013 addi x0, x1, 7
I 00000038 001006b3 add x13, x0, x1
C 13 00000005
I 0000003c 00509733 sll x14, x1, x5
C 14 0000000a
I 00000040 405157b3 sra x15, x2, x5
C 15 fffffffe
I 00000044 00515833 srl x16, x2, x5
C 16 7ffffffe
I 00000048 0083f8b3 and x17, x7, x8
C 17 00000000
I 0000004c 0083e933 or x18, x7, x8
C 18 ffffffff
I 00000050 0040c0b3 xor x1, x1, x4
C 1 0000000d
I 00000054 00108093 addi x1, x1, 1
C 1 0000000e
I 00000058 00108093 addi x1, x1, 1
C 1 0000000f
I 0000005c 403089b3 sub x19, x1, x3
C 19 0000000d
I 00000060 00100073 ebreak
I 00000064 00100a13 addi x20, x0, 1
H 1
I 00000000 00500093 addi x1, x0, 5
C 1 00000005
I 00000004 00108133 add x2, x1, x1
C 2 0000000a
I 00000008 ffffffff illegal
I 0000000c 00100193 addi x3, x0, 1
H 2
